//--- Makefile
LOG = sim.log

sim:
	verilator --binary --top-module procTb -f proc.f -o procSim
	./obj_dir/procSim | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- hw/decode.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module decode import procPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  wordT   instruction,
	input  wordT   pcPlusTwo,
	input  logic   stall,
	input  logic   jrTaken,
	input  logic   wbValid,
	input  regIdxT wbReg,
	input  wordT   wbData,
	output regIdxT rsIdx,
	output regIdxT rtIdx,
	output logic   usesRs,
	output logic   usesRt,
	output wordT   rsData,
	output wordT   rtData,
	output wordT   immExt,
	output aluOpT  aluOp,
	output logic   aluSrcImm,
	output logic   memRead,
	output logic   memWrite,
	output wbSelT  wbSel,
	output regIdxT destReg,
	output logic   regWrite,
	output logic   isJr,
	output logic   isHalt,
	output wordT   linkValue,
	output logic   branchTaken,
	output wordT   branchTarget,
	output logic   haltDecoded,
	output logic   err
);

	wordT ifIdInstr;
	wordT ifIdPcPlusTwo;
	wordT regs [`REG_COUNT];
	opcodeT opcode;
	wordT immI;
	wordT immB;
	wordT immJ;
	logic takeBranch;
	logic illegal;

	// A JR redirect in the IF/ID register wins over the stall hold
	always_ff @(posedge clk) begin
		if (rst || jrTaken) begin
			ifIdInstr <= {OP_NOP, 11'd0};
		end else if (!stall) begin
			ifIdInstr <= branchTaken ? {OP_NOP, 11'd0} : instruction;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			ifIdPcPlusTwo <= pcPlusTwo;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbValid) begin
			regs[wbReg] <= wbData;
		end
	end

	assign opcode = opcodeT'(ifIdInstr[15:11]);
	assign rsIdx = ifIdInstr[10:8];
	assign rtIdx = ifIdInstr[7:5];

	// Write-back passes straight through to the read ports
	assign rsData = (wbValid && wbReg == rsIdx) ? wbData : regs[rsIdx];
	assign rtData = (wbValid && wbReg == rtIdx) ? wbData : regs[rtIdx];

	assign immI = {{(`WORD_W-5){ifIdInstr[4]}}, ifIdInstr[4:0]};
	assign immB = {{(`WORD_W-8){ifIdInstr[7]}}, ifIdInstr[7:0]};
	assign immJ = {{(`WORD_W-11){ifIdInstr[10]}}, ifIdInstr[10:0]};
	assign linkValue = ifIdPcPlusTwo;

	always_comb begin
		usesRs = 1'b0;
		usesRt = 1'b0;
		immExt = immI;
		aluOp = ALU_ADD;
		aluSrcImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		wbSel = WB_ALU;
		destReg = ifIdInstr[4:2];
		regWrite = 1'b0;
		isJr = 1'b0;
		isHalt = 1'b0;
		takeBranch = 1'b0;
		illegal = 1'b0;
		case (opcode)
			OP_NOP: ;
			OP_HALT: isHalt = 1'b1;
			OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SLT: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				regWrite = 1'b1;
				aluOp = (opcode == OP_SUB) ? ALU_SUB :
					(opcode == OP_AND) ? ALU_AND :
					(opcode == OP_XOR) ? ALU_XOR :
					(opcode == OP_SLT) ? ALU_SLT : ALU_ADD;
			end
			OP_ADDI, OP_ANDI, OP_LD: begin
				usesRs = 1'b1;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
				destReg = rtIdx;
				aluOp = (opcode == OP_ANDI) ? ALU_AND : ALU_ADD;
				memRead = (opcode == OP_LD);
				wbSel = (opcode == OP_LD) ? WB_MEM : WB_ALU;
			end
			OP_ST: begin
				usesRs = 1'b1;
				usesRt = 1'b1;
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
			end
			OP_BEQZ, OP_BNEZ: begin
				usesRs = 1'b1;
				immExt = immB;
				takeBranch = (rsData == '0) ^ (opcode == OP_BNEZ);
			end
			OP_J, OP_JAL: begin
				immExt = immJ;
				takeBranch = 1'b1;
				regWrite = (opcode == OP_JAL);
				destReg = regIdxT'(`REG_COUNT - 1);
				wbSel = WB_LINK;
			end
			OP_JR: begin
				usesRs = 1'b1;
				immExt = immB;
				isJr = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

	assign branchTarget = ifIdPcPlusTwo + immExt;
	assign branchTaken = takeBranch & ~stall & ~jrTaken;
	assign haltDecoded = isHalt & ~jrTaken;

	always_ff @(posedge clk) begin
		if (rst) begin
			err <= 1'b0;
		end else if (illegal && !jrTaken) begin
			err <= 1'b1;
		end
	end

endmodule

//--- hw/execute.sv
`timescale 1ns/1ps

module execute import procPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   stall,
	input  wordT   rsData,
	input  wordT   rtData,
	input  wordT   immExt,
	input  aluOpT  aluOp,
	input  logic   aluSrcImm,
	input  logic   memRead,
	input  logic   memWrite,
	input  wbSelT  wbSel,
	input  regIdxT destReg,
	input  logic   regWrite,
	input  logic   isJr,
	input  logic   isHalt,
	input  wordT   linkValue,
	output wordT   aluResult,
	output wordT   storeData,
	output logic   exMemRead,
	output logic   exMemWrite,
	output wbSelT  exWbSel,
	output regIdxT exDestReg,
	output logic   exRegWrite,
	output logic   exHalt,
	output wordT   exLink,
	output logic   jrTaken,
	output wordT   jrTarget
);

	wordT exRs;
	wordT exImm;
	aluOpT exAluOp;
	logic exAluSrcImm;
	logic exIsJr;
	wordT opB;

	// ID/EX register takes a bubble on stall or when a JR discards decode
	always_ff @(posedge clk) begin
		if (rst || stall || jrTaken) begin
			exMemRead <= 1'b0;
			exMemWrite <= 1'b0;
			exRegWrite <= 1'b0;
			exHalt <= 1'b0;
			exIsJr <= 1'b0;
		end else begin
			exMemRead <= memRead;
			exMemWrite <= memWrite;
			exRegWrite <= regWrite;
			exHalt <= isHalt;
			exIsJr <= isJr;
		end
	end

	always_ff @(posedge clk) begin
		exRs <= rsData;
		storeData <= rtData;
		exImm <= immExt;
		exAluOp <= aluOp;
		exAluSrcImm <= aluSrcImm;
		exWbSel <= wbSel;
		exDestReg <= destReg;
		exLink <= linkValue;
	end

	assign opB = exAluSrcImm ? exImm : storeData;

	always_comb begin
		case (exAluOp)
			ALU_SUB: aluResult = exRs - opB;
			ALU_AND: aluResult = exRs & opB;
			ALU_XOR: aluResult = exRs ^ opB;
			ALU_SLT: aluResult = wordT'($signed(exRs) < $signed(opB));
			default: aluResult = exRs + opB;
		endcase
	end

	assign jrTaken = exIsJr;
	assign jrTarget = exRs + exImm;

endmodule

//--- hw/fetch.sv
`timescale 1ns/1ps

module fetch import procPkg::*; (
	input  logic clk,
	input  logic rst,
	input  wordT instr,
	input  logic stall,
	input  logic branchTaken,
	input  wordT branchTarget,
	input  logic jrTaken,
	input  wordT jrTarget,
	input  logic haltDecoded,
	output wordT instrAddr,
	output wordT instruction,
	output wordT pcPlusTwo
);

	wordT pc;
	wordT nextPc;
	logic haltHold;
	logic halting;

	assign halting = haltHold | haltDecoded;

	always_comb begin
		if (jrTaken) begin
			nextPc = jrTarget;
		end else if (stall) begin
			nextPc = pc;
		end else if (branchTaken) begin
			nextPc = branchTarget;
		end else if (halting) begin
			nextPc = pc;
		end else begin
			nextPc = pcPlusTwo;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			haltHold <= 1'b0;
		end else begin
			pc <= nextPc;
			haltHold <= halting;
		end
	end

	assign instrAddr = pc;
	assign pcPlusTwo = pc + wordT'(2);
	// Younger words behind a HALT never enter decode
	assign instruction = halting ? {OP_NOP, 11'd0} : instr;

endmodule

//--- hw/hazardDetection.sv
`timescale 1ns/1ps

module hazardDetection import procPkg::*; (
	input  regIdxT rsIdx,
	input  regIdxT rtIdx,
	input  logic   usesRs,
	input  logic   usesRt,
	input  regIdxT exDestReg,
	input  logic   exRegWrite,
	input  regIdxT memDestReg,
	input  logic   memRegWrite,
	output logic   stall
);

	logic rsHit;
	logic rtHit;

	// Write-back is bypassed in the register file, so only EX and MEM matter
	assign rsHit = usesRs &&
		((exRegWrite && exDestReg == rsIdx) || (memRegWrite && memDestReg == rsIdx));
	assign rtHit = usesRt &&
		((exRegWrite && exDestReg == rtIdx) || (memRegWrite && memDestReg == rtIdx));

	assign stall = rsHit | rtHit;

endmodule

//--- hw/memWriteback.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module memWriteback import procPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  wordT   aluResult,
	input  wordT   storeData,
	input  logic   exMemRead,
	input  logic   exMemWrite,
	input  wbSelT  exWbSel,
	input  regIdxT exDestReg,
	input  logic   exRegWrite,
	input  logic   exHalt,
	input  wordT   exLink,
	output regIdxT memDestReg,
	output logic   memRegWrite,
	output logic   wbValid,
	output regIdxT wbReg,
	output wordT   wbData,
	output logic   halted
);

	localparam int ADDR_W = $clog2(`DMEM_DEPTH);

	wordT memAlu;
	wordT memStore;
	wordT memLink;
	wbSelT memWbSel;
	logic memRdEn;
	logic memWrEn;
	logic memHalt;
	wordT dmem [`DMEM_DEPTH];
	logic [ADDR_W-1:0] dAddr;
	wordT loadData;
	wordT memResult;

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (rst) begin
			memRdEn <= 1'b0;
			memWrEn <= 1'b0;
			memRegWrite <= 1'b0;
			memHalt <= 1'b0;
		end else begin
			memRdEn <= exMemRead;
			memWrEn <= exMemWrite;
			memRegWrite <= exRegWrite;
			memHalt <= exHalt;
		end
	end

	always_ff @(posedge clk) begin
		memAlu <= aluResult;
		memStore <= storeData;
		memLink <= exLink;
		memWbSel <= exWbSel;
		memDestReg <= exDestReg;
	end

	assign dAddr = memAlu[ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (memWrEn) begin
			dmem[dAddr] <= memStore;
		end
	end

	assign loadData = memRdEn ? dmem[dAddr] : '0;

	always_comb begin
		case (memWbSel)
			WB_MEM: memResult = loadData;
			WB_LINK: memResult = memLink;
			default: memResult = memAlu;
		endcase
	end

	// MEM/WB register with halted rising as the HALT reaches write-back
	always_ff @(posedge clk) begin
		if (rst) begin
			wbValid <= 1'b0;
			halted <= 1'b0;
		end else begin
			wbValid <= memRegWrite;
			halted <= halted | memHalt;
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= memDestReg;
		wbData <= memResult;
	end

endmodule

//--- hw/proc.sv
`timescale 1ns/1ps

module proc import procPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  wordT   instr,
	output wordT   instrAddr,
	output logic   wbValid,
	output regIdxT wbReg,
	output wordT   wbData,
	output logic   halted,
	output logic   err
);

	wordT instruction;
	wordT pcPlusTwo;
	logic stall;
	logic branchTaken;
	wordT branchTarget;
	logic haltDecoded;
	logic jrTaken;
	wordT jrTarget;

	regIdxT rsIdx;
	regIdxT rtIdx;
	logic usesRs;
	logic usesRt;
	wordT rsData;
	wordT rtData;
	wordT immExt;
	aluOpT aluOp;
	logic aluSrcImm;
	logic memRead;
	logic memWrite;
	wbSelT wbSel;
	regIdxT destReg;
	logic regWrite;
	logic isJr;
	logic isHalt;
	wordT linkValue;

	wordT aluResult;
	wordT storeData;
	logic exMemRead;
	logic exMemWrite;
	wbSelT exWbSel;
	regIdxT exDestReg;
	logic exRegWrite;
	logic exHalt;
	wordT exLink;
	regIdxT memDestReg;
	logic memRegWrite;

	fetch fetchStage (
		.clk(clk), .rst(rst), .instr(instr), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.jrTaken(jrTaken), .jrTarget(jrTarget), .haltDecoded(haltDecoded),
		.instrAddr(instrAddr), .instruction(instruction), .pcPlusTwo(pcPlusTwo)
	);

	decode decodeStage (
		.clk(clk), .rst(rst), .instruction(instruction), .pcPlusTwo(pcPlusTwo),
		.stall(stall), .jrTaken(jrTaken),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.rsIdx(rsIdx), .rtIdx(rtIdx), .usesRs(usesRs), .usesRt(usesRt),
		.rsData(rsData), .rtData(rtData), .immExt(immExt),
		.aluOp(aluOp), .aluSrcImm(aluSrcImm), .memRead(memRead), .memWrite(memWrite),
		.wbSel(wbSel), .destReg(destReg), .regWrite(regWrite),
		.isJr(isJr), .isHalt(isHalt), .linkValue(linkValue),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.haltDecoded(haltDecoded), .err(err)
	);

	hazardDetection hdu (
		.rsIdx(rsIdx), .rtIdx(rtIdx), .usesRs(usesRs), .usesRt(usesRt),
		.exDestReg(exDestReg), .exRegWrite(exRegWrite),
		.memDestReg(memDestReg), .memRegWrite(memRegWrite),
		.stall(stall)
	);

	execute executeStage (
		.clk(clk), .rst(rst), .stall(stall),
		.rsData(rsData), .rtData(rtData), .immExt(immExt),
		.aluOp(aluOp), .aluSrcImm(aluSrcImm), .memRead(memRead), .memWrite(memWrite),
		.wbSel(wbSel), .destReg(destReg), .regWrite(regWrite),
		.isJr(isJr), .isHalt(isHalt), .linkValue(linkValue),
		.aluResult(aluResult), .storeData(storeData),
		.exMemRead(exMemRead), .exMemWrite(exMemWrite), .exWbSel(exWbSel),
		.exDestReg(exDestReg), .exRegWrite(exRegWrite), .exHalt(exHalt),
		.exLink(exLink), .jrTaken(jrTaken), .jrTarget(jrTarget)
	);

	memWriteback memWbStage (
		.clk(clk), .rst(rst), .aluResult(aluResult), .storeData(storeData),
		.exMemRead(exMemRead), .exMemWrite(exMemWrite), .exWbSel(exWbSel),
		.exDestReg(exDestReg), .exRegWrite(exRegWrite), .exHalt(exHalt),
		.exLink(exLink), .memDestReg(memDestReg), .memRegWrite(memRegWrite),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted)
	);

endmodule

//--- hw/procPkg.sv
`include "proc_cfg.svh"

package procPkg;

	typedef logic [`WORD_W-1:0] wordT;
	typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

	// Held in instruction bits 15..11
	typedef enum logic [4:0] {
		OP_NOP  = 5'd0,
		OP_HALT = 5'd1,
		OP_ADD  = 5'd2,
		OP_SUB  = 5'd3,
		OP_AND  = 5'd4,
		OP_XOR  = 5'd5,
		OP_SLT  = 5'd6,
		OP_ADDI = 5'd7,
		OP_ANDI = 5'd8,
		OP_LD   = 5'd9,
		OP_ST   = 5'd10,
		OP_BEQZ = 5'd11,
		OP_BNEZ = 5'd12,
		OP_J    = 5'd13,
		OP_JAL  = 5'd14,
		OP_JR   = 5'd15
	} opcodeT;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_XOR = 3'd3,
		ALU_SLT = 3'd4
	} aluOpT;

	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_LINK = 2'd2
	} wbSelT;

endpackage

//--- hw/proc_cfg.svh
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// Datapath and instruction width
`define WORD_W 16

// Architectural registers
`define REG_COUNT 8

// Data memory words, word addressed
`define DMEM_DEPTH 256

`endif

//--- proc.f
+incdir+hw
+incdir+verification
hw/procPkg.sv
hw/fetch.sv
hw/decode.sv
hw/hazardDetection.sv
hw/execute.sv
hw/memWriteback.sv
hw/proc.sv
verification/procTb.sv

//--- verification/procRefModel.svh
`ifndef PROC_REF_MODEL_SVH
`define PROC_REF_MODEL_SVH

// Instruction-level model of the program in imem stepping one instruction at a time
task automatic runModel();
	wordT regs [`REG_COUNT];
	wordT dmem [`DMEM_DEPTH];
	wordT pc;
	wordT ins;
	wordT a;
	wordT b;
	wordT imm5;
	wordT imm8;
	wordT imm11;
	wordT ea;
	wordT res;
	regIdxT dst;
	logic wr;
	logic done;
	int steps;
	for (int i = 0; i < `REG_COUNT; i++) begin
		regs[i] = '0;
	end
	for (int i = 0; i < `DMEM_DEPTH; i++) begin
		dmem[i] = '0;
	end
	expReg.delete();
	expData.delete();
	expErr = 1'b0;
	pc = '0;
	done = 1'b0;
	steps = 0;
	while (!done && steps < 1000) begin
		ins = imem[pc[8:1]];
		a = regs[ins[10:8]];
		b = regs[ins[7:5]];
		imm5 = {{(`WORD_W-5){ins[4]}}, ins[4:0]};
		imm8 = {{(`WORD_W-8){ins[7]}}, ins[7:0]};
		imm11 = {{(`WORD_W-11){ins[10]}}, ins[10:0]};
		ea = a + imm5;
		// From here pc is the address after this instruction
		pc = pc + wordT'(2);
		dst = ins[4:2];
		wr = 1'b1;
		res = '0;
		case (ins[15:11])
			OP_NOP: wr = 1'b0;
			OP_HALT: begin
				wr = 1'b0;
				done = 1'b1;
			end
			OP_ADD: res = a + b;
			OP_SUB: res = a - b;
			OP_AND: res = a & b;
			OP_XOR: res = a ^ b;
			OP_SLT: res = ($signed(a) < $signed(b)) ? wordT'(1) : wordT'(0);
			OP_ADDI: begin
				dst = ins[7:5];
				res = ea;
			end
			OP_ANDI: begin
				dst = ins[7:5];
				res = a & imm5;
			end
			OP_LD: begin
				dst = ins[7:5];
				res = dmem[ea[7:0]];
			end
			OP_ST: begin
				wr = 1'b0;
				dmem[ea[7:0]] = b;
			end
			OP_BEQZ: begin
				wr = 1'b0;
				if (a == '0) begin
					pc = pc + imm8;
				end
			end
			OP_BNEZ: begin
				wr = 1'b0;
				if (a != '0) begin
					pc = pc + imm8;
				end
			end
			OP_J: begin
				wr = 1'b0;
				pc = pc + imm11;
			end
			OP_JAL: begin
				dst = 3'd7;
				res = pc;
				pc = pc + imm11;
			end
			OP_JR: begin
				wr = 1'b0;
				pc = a + imm8;
			end
			default: begin
				wr = 1'b0;
				expErr = 1'b1;
			end
		endcase
		if (wr) begin
			regs[dst] = res;
			expReg.push_back(dst);
			expData.push_back(res);
		end
		steps++;
	end
endtask

`endif

//--- verification/procTb.sv
`timescale 1ns/1ps
`include "proc_cfg.svh"

module procTb import procPkg::*; ();

	localparam int IMEM_WORDS = 256;
	localparam int BODY_LEN = 40;
	localparam int HALT_TIMEOUT = 2000;

	logic clk;
	logic rst;
	wordT instr;
	wordT instrAddr;
	logic wbValid;
	regIdxT wbReg;
	wordT wbData;
	logic halted;
	logic err;

	wordT imem [IMEM_WORDS];
	regIdxT expReg [$];
	wordT expData [$];
	logic expErr;
	regIdxT gotReg [$];
	wordT gotData [$];
	int checkCount;
	int errCount;
	logic timedOut;

	proc dut_i (
		.clk(clk), .rst(rst), .instr(instr), .instrAddr(instrAddr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
		.halted(halted), .err(err)
	);

	`include "procRefModel.svh"

	always #10 clk = ~clk;

	// Instruction port answered in the same cycle
	assign instr = imem[instrAddr[8:1]];

	always @(negedge clk) begin
		if (!rst && wbValid) begin
			gotReg.push_back(wbReg);
			gotData.push_back(wbData);
		end
	end

	task automatic checkRegIdx(string name, regIdxT expected, regIdxT actual);
		checkCount++;
		if (expected !== actual) begin
			errCount++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic checkWord(string name, wordT expected, wordT actual);
		checkCount++;
		if (expected !== actual) begin
			errCount++;
			$display("** Error %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
		end
	endtask

	task automatic checkFlag(string name, logic expected, logic actual);
		checkCount++;
		if (expected !== actual) begin
			errCount++;
			$display("** Error %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	function automatic wordT rFormat(opcodeT op, regIdxT rs, regIdxT rt, regIdxT rd);
		return {op, rs, rt, rd, 2'b00};
	endfunction

	function automatic wordT iFormat(opcodeT op, regIdxT rs, regIdxT rt, logic [4:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic wordT branchWord(opcodeT op, regIdxT rs, logic [7:0] off);
		return {op, rs, off};
	endfunction

	function automatic wordT jumpWord(opcodeT op, logic [10:0] off);
		return {op, off};
	endfunction

	function automatic regIdxT randomReg(int lo, int hi);
		return regIdxT'($urandom_range(hi, lo));
	endfunction

	function automatic wordT randomAlu();
		opcodeT op;
		wordT word;
		op = opcodeT'(5'($urandom_range(8, 2)));
		if (op == OP_ADDI || op == OP_ANDI) begin
			word = iFormat(op, randomReg(0, 7), randomReg(0, 7), 5'($urandom));
		end else begin
			word = rFormat(op, randomReg(0, 7), randomReg(0, 7), randomReg(0, 7));
		end
		return word;
	endfunction

	task automatic clearImem();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			// Illegal words tagged with their index fill the space outside the program
			imem[i] = {1'b1, 7'd0, 8'(i)};
		end
	endtask

	task automatic aluProgram(int len);
		clearImem();
		for (int i = 0; i < len; i++) begin
			imem[i] = randomAlu();
		end
		imem[len] = {OP_HALT, 11'd0};
	endtask

	task automatic memProgram();
		int kind;
		clearImem();
		// r1 is never written and stays zero, so addresses cluster and collide
		for (int i = 0; i < BODY_LEN; i++) begin
			kind = $urandom_range(2, 0);
			case (kind)
				0: imem[i] = iFormat(OP_LD, 3'd1, randomReg(2, 5), 5'($urandom_range(7, 0)));
				1: imem[i] = iFormat(OP_ST, 3'd1, randomReg(2, 5), 5'($urandom_range(7, 0)));
				default: imem[i] = iFormat(OP_ADDI, randomReg(2, 5), randomReg(2, 5), 5'($urandom));
			endcase
		end
		imem[BODY_LEN] = {OP_HALT, 11'd0};
	endtask

	task automatic flowProgram();
		int i;
		int kind;
		int skip;
		int base;
		regIdxT r;
		// Marks the targets of earlier jumps so none lands inside a JR setup
		logic landing [BODY_LEN + 1];
		clearImem();
		for (int k = 0; k <= BODY_LEN; k++) begin
			landing[k] = 1'b0;
		end
		i = 0;
		while (i < BODY_LEN) begin
			kind = $urandom_range(5, 0);
			skip = $urandom_range(3, 0);
			if (i + 1 + skip > BODY_LEN) begin
				skip = BODY_LEN - i - 1;
			end
			if (kind == 2) begin
				imem[i] = branchWord($urandom_range(1, 0) ? OP_BNEZ : OP_BEQZ,
					randomReg(0, 7), 8'(2 * skip));
				landing[i + 1 + skip] = 1'b1;
				i++;
			end else if (kind == 3 || kind == 4) begin
				imem[i] = jumpWord(kind == 3 ? OP_J : OP_JAL, 11'(2 * skip));
				landing[i + 1 + skip] = 1'b1;
				i++;
			end else if (kind == 5 && i + 3 <= BODY_LEN &&
					!landing[i + 1] && !landing[i + 2]) begin
				if (i + 3 + skip > BODY_LEN) begin
					skip = BODY_LEN - i - 3;
				end
				// Clear, then load a known base so the JR target is forward
				r = randomReg(0, 6);
				base = 2 * $urandom_range(7, 0);
				imem[i] = iFormat(OP_ANDI, r, r, 5'd0);
				imem[i + 1] = iFormat(OP_ADDI, r, r, 5'(base));
				imem[i + 2] = branchWord(OP_JR, r, 8'(2 * (i + 3 + skip) - base));
				landing[i + 3 + skip] = 1'b1;
				i += 3;
			end else begin
				imem[i] = randomAlu();
				i++;
			end
		end
		imem[BODY_LEN] = {OP_HALT, 11'd0};
	endtask

	task automatic illegalProgram();
		int at;
		aluProgram(30);
		at = $urandom_range(25, 3);
		imem[at] = {5'($urandom_range(31, 16)), 11'($urandom)};
		imem[at + 3] = {5'($urandom_range(31, 16)), 11'($urandom)};
	endtask

	task automatic applyReset();
		@(posedge clk);
		#1;
		rst = 1'b1;
		gotReg.delete();
		gotData.delete();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
	endtask

	task automatic runProgram(string name, logic holdCheck, logic resetCheck);
		int cycles;
		int count;
		int errStart;
		int checkStart;
		wordT addr;
		errStart = errCount;
		checkStart = checkCount;
		if (!timedOut) begin
			runModel();
			applyReset();
			cycles = 0;
			while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
				@(negedge clk);
				cycles++;
			end
			if (halted !== 1'b1) begin
				errCount++;
				timedOut = 1'b1;
				$display("%s: halted did not rise within %0d cycles", name, HALT_TIMEOUT);
			end else begin
				if (holdCheck) begin
					addr = instrAddr;
					for (int i = 0; i < 20; i++) begin
						@(negedge clk);
						checkWord({name, " instrAddr"}, addr, instrAddr);
						checkFlag({name, " halted"}, 1'b1, halted);
					end
				end
				checkFlag({name, " err"}, expErr, err);
				if (gotReg.size() != expReg.size()) begin
					errCount++;
					$display("%s: DUT retired %0d values but the model expects %0d",
						name, gotReg.size(), expReg.size());
				end
				count = (gotReg.size() < expReg.size()) ? gotReg.size() : expReg.size();
				for (int i = 0; i < count; i++) begin
					checkRegIdx($sformatf("%s retire %0d reg", name, i), expReg[i], gotReg[i]);
					checkWord($sformatf("%s retire %0d data", name, i), expData[i], gotData[i]);
				end
				if (resetCheck) begin
					applyReset();
					@(negedge clk);
					checkFlag({name, " err after reset"}, 1'b0, err);
				end
			end
			$display("%s: %0d checks, %0d errors", name, checkCount - checkStart,
				errCount - errStart);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		checkCount = 0;
		errCount = 0;
		timedOut = 1'b0;
		expErr = 1'b0;
		void'($urandom(53879));
		clearImem();

		aluProgram(BODY_LEN);
		runProgram("alu", 1'b0, 1'b0);
		memProgram();
		runProgram("loadStore", 1'b0, 1'b0);
		flowProgram();
		runProgram("controlFlow", 1'b0, 1'b0);
		aluProgram(12);
		runProgram("haltHold", 1'b1, 1'b0);
		illegalProgram();
		runProgram("illegalOpcode", 1'b0, 1'b1);

		$display("tests: 5, checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0 && !timedOut) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
